//--- verilog/ex_pkg.sv
`default_nettype none

package ex_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [15:0] imm_t;
    typedef logic [4:0]  ex_code_t;
    typedef logic [3:0]  wstrb_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_t;

    // signed overflow check requested by decode
    typedef enum logic [1:0] {
        OV_NONE,
        OV_ADD,
        OV_SUB
    } ov_check_t;

    typedef enum logic [3:0] {
        MEM_NONE,
        MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU,
        MEM_SW, MEM_SH, MEM_SB
    } mem_op_t;

    typedef enum logic [2:0] {
        HILO_NONE,
        HILO_MFHI, HILO_MFLO,
        HILO_MTHI, HILO_MTLO,
        HILO_MULT, HILO_MULTU
    } hilo_op_t;

    // cp0 cause codes
    localparam ex_code_t EX_NONE = 5'd0;
    localparam ex_code_t EX_ADEL = 5'd4;
    localparam ex_code_t EX_ADES = 5'd5;
    localparam ex_code_t EX_OV   = 5'd12;

    localparam wstrb_t ALL_LANES = 4'b1111;

endpackage

`default_nettype wire

//--- verilog/ex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
    input  ex_pkg::alu_op_t   alu_op,
    input  ex_pkg::ov_check_t ov_check,
    input  logic              src1_is_sa,
    input  logic              src1_is_pc,
    input  logic              src2_is_imm,
    input  logic              src2_is_imm_zero,
    input  logic              src2_is_8,
    input  ex_pkg::imm_t      imm,
    input  ex_pkg::word_t     rs_value,
    input  ex_pkg::word_t     rt_value,
    input  ex_pkg::word_t     pc,
    output ex_pkg::word_t     result,
    output logic              overflow
);
    import ex_pkg::*;

    word_t      src1;
    word_t      src2;
    logic [4:0] shamt;

    assign src1 = src1_is_sa ? {27'b0, imm[10:6]} :
                  src1_is_pc ? pc                 :
                               rs_value;

    assign src2 = src2_is_imm_zero ? {16'b0, imm}          :
                  src2_is_imm      ? {{16{imm[15]}}, imm}  :
                  src2_is_8        ? 32'd8                 :
                                     rt_value;

    // shifts take the amount from source 1
    assign shamt = src1[4:0];

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = src1 + src2;
            ALU_SUB:  result = src1 - src2;
            ALU_SLT:  result = {31'b0, $signed(src1) < $signed(src2)};
            ALU_SLTU: result = {31'b0, src1 < src2};
            ALU_AND:  result = src1 & src2;
            ALU_OR:   result = src1 | src2;
            ALU_XOR:  result = src1 ^ src2;
            ALU_NOR:  result = ~(src1 | src2);
            ALU_SLL:  result = src2 << shamt;
            ALU_SRL:  result = src2 >> shamt;
            ALU_SRA:  result = word_t'($signed(src2) >>> shamt);
            ALU_LUI:  result = {src2[15:0], 16'b0};
            default:  result = '0;
        endcase
    end

    always_comb begin
        case (ov_check)
            OV_ADD:  overflow = (src1[31] == src2[31]) && (result[31] != src1[31]);
            // sub flips the sign of source 2
            OV_SUB:  overflow = (src1[31] != src2[31]) && (result[31] != src1[31]);
            default: overflow = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/ex_hilo.sv
`timescale 1ns/1ps
`default_nettype none

module ex_hilo (
    input  logic             clk,
    input  logic             reset,
    input  ex_pkg::hilo_op_t hilo_op,
    input  ex_pkg::word_t    rs_value,
    input  ex_pkg::word_t    rt_value,
    input  logic             commit,
    output ex_pkg::word_t    move_value
);
    import ex_pkg::*;

    word_t              hi;
    word_t              lo;
    logic signed [63:0] prod_signed;
    logic        [63:0] prod_unsigned;

    assign prod_signed   = $signed({{32{rs_value[31]}}, rs_value}) *
                           $signed({{32{rt_value[31]}}, rt_value});
    assign prod_unsigned = {32'b0, rs_value} * {32'b0, rt_value};

    // written only when the instruction leaves the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (commit) begin
            case (hilo_op)
                HILO_MULT: begin
                    hi <= prod_signed[63:32];
                    lo <= prod_signed[31:0];
                end
                HILO_MULTU: begin
                    hi <= prod_unsigned[63:32];
                    lo <= prod_unsigned[31:0];
                end
                HILO_MTHI: hi <= rs_value;
                HILO_MTLO: lo <= rs_value;
                default: begin
                end
            endcase
        end
    end

    assign move_value = (hilo_op == HILO_MFHI) ? hi : lo;

endmodule

`default_nettype wire

//--- verilog/ex_mem_req.sv
`timescale 1ns/1ps
`default_nettype none

module ex_mem_req (
    input  logic            clk,
    input  logic            reset,
    input  ex_pkg::mem_op_t mem_op,
    input  ex_pkg::word_t   addr,
    input  ex_pkg::word_t   rt_value,
    input  logic            active,
    input  logic            data_addr_ok,
    input  logic            advance,
    output logic            addr_error,
    output logic            req_done,
    output logic            data_req,
    output logic            data_wr,
    output ex_pkg::word_t   data_addr,
    output ex_pkg::wstrb_t  data_wstrb,
    output ex_pkg::word_t   data_wdata
);
    import ex_pkg::*;

    logic   is_mem;
    logic   is_store;
    logic   word_op;
    logic   half_op;
    logic   handshake;
    logic   addr_taken;
    wstrb_t store_strb;

    assign is_mem   = (mem_op != MEM_NONE);
    assign is_store = (mem_op == MEM_SW) || (mem_op == MEM_SH) || (mem_op == MEM_SB);
    assign word_op  = (mem_op == MEM_LW) || (mem_op == MEM_SW);
    assign half_op  = (mem_op == MEM_LH) || (mem_op == MEM_LHU) || (mem_op == MEM_SH);

    // byte accesses have no alignment rule
    assign addr_error = (word_op && (addr[1:0] != 2'b00)) || (half_op && addr[0]);

    assign data_req  = active && is_mem && !addr_taken;
    assign handshake = data_req && data_addr_ok;

    // instructions with an exception never wait on memory
    assign req_done = !active || !is_mem || handshake || addr_taken;

    // address accepted while the stage is still stalled
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_taken <= 1'b0;
        end else if (advance) begin
            addr_taken <= 1'b0;
        end else if (handshake) begin
            addr_taken <= 1'b1;
        end
    end

    always_comb begin
        case (mem_op)
            MEM_SB:  store_strb = 4'b0001 << addr[1:0];
            MEM_SH:  store_strb = addr[1] ? 4'b1100 : 4'b0011;
            MEM_SW:  store_strb = ALL_LANES;
            default: store_strb = 4'b0000;
        endcase
    end

    assign data_wstrb = (active && is_store) ? store_strb : 4'b0000;

    assign data_wdata = (mem_op == MEM_SB) ? {4{rt_value[7:0]}}  :
                        (mem_op == MEM_SH) ? {2{rt_value[15:0]}} :
                                             rt_value;

    assign data_wr   = is_store;
    assign data_addr = addr;

endmodule

`default_nettype wire

//--- verilog/exe_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage (
    input  logic              clk,
    input  logic              reset,
    input  logic              in_valid,
    output logic              in_allowin,
    input  ex_pkg::alu_op_t   alu_op,
    input  ex_pkg::ov_check_t ov_check,
    input  logic              src1_is_sa,
    input  logic              src1_is_pc,
    input  logic              src2_is_imm,
    input  logic              src2_is_imm_zero,
    input  logic              src2_is_8,
    input  logic              gr_we,
    input  ex_pkg::reg_idx_t  dest,
    input  ex_pkg::imm_t      imm,
    input  ex_pkg::word_t     rs_value,
    input  ex_pkg::word_t     rt_value,
    input  ex_pkg::word_t     pc,
    input  ex_pkg::mem_op_t   mem_op,
    input  ex_pkg::hilo_op_t  hilo_op,
    output logic              out_valid,
    input  logic              out_allowin,
    output ex_pkg::word_t     out_result,
    output ex_pkg::reg_idx_t  out_dest,
    output logic              out_gr_we,
    output ex_pkg::word_t     out_pc,
    output logic              out_load,
    output ex_pkg::ex_code_t  out_ex_code,
    output ex_pkg::word_t     out_bad_vaddr,
    output logic              data_req,
    output logic              data_wr,
    output ex_pkg::word_t     data_addr,
    output ex_pkg::wstrb_t    data_wstrb,
    output ex_pkg::word_t     data_wdata,
    input  logic              data_addr_ok
);
    import ex_pkg::*;

    logic      es_valid;
    logic      ready_go;
    logic      advance;
    alu_op_t   es_alu_op;
    ov_check_t es_ov_check;
    logic      es_src1_is_sa;
    logic      es_src1_is_pc;
    logic      es_src2_is_imm;
    logic      es_src2_is_imm_zero;
    logic      es_src2_is_8;
    logic      es_gr_we;
    reg_idx_t  es_dest;
    imm_t      es_imm;
    word_t     es_rs_value;
    word_t     es_rt_value;
    word_t     es_pc;
    mem_op_t   es_mem_op;
    hilo_op_t  es_hilo_op;
    word_t     alu_result;
    word_t     move_value;
    logic      overflow;
    logic      addr_error;
    logic      addr_fault;
    logic      has_ex;
    logic      is_load;

    assign in_allowin = !es_valid || (ready_go && out_allowin);
    assign out_valid  = es_valid && ready_go;
    assign advance    = out_valid && out_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            es_valid <= 1'b0;
        end else if (in_allowin) begin
            es_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            es_alu_op           <= alu_op;
            es_ov_check         <= ov_check;
            es_src1_is_sa       <= src1_is_sa;
            es_src1_is_pc       <= src1_is_pc;
            es_src2_is_imm      <= src2_is_imm;
            es_src2_is_imm_zero <= src2_is_imm_zero;
            es_src2_is_8        <= src2_is_8;
            es_gr_we            <= gr_we;
            es_dest             <= dest;
            es_imm              <= imm;
            es_rs_value         <= rs_value;
            es_rt_value         <= rt_value;
            es_pc               <= pc;
            es_mem_op           <= mem_op;
            es_hilo_op          <= hilo_op;
        end
    end

    ex_alu u_alu (
        .alu_op           (es_alu_op),
        .ov_check         (es_ov_check),
        .src1_is_sa       (es_src1_is_sa),
        .src1_is_pc       (es_src1_is_pc),
        .src2_is_imm      (es_src2_is_imm),
        .src2_is_imm_zero (es_src2_is_imm_zero),
        .src2_is_8        (es_src2_is_8),
        .imm              (es_imm),
        .rs_value         (es_rs_value),
        .rt_value         (es_rt_value),
        .pc               (es_pc),
        .result           (alu_result),
        .overflow         (overflow)
    );

    ex_hilo u_hilo (
        .clk        (clk),
        .reset      (reset),
        .hilo_op    (es_hilo_op),
        .rs_value   (es_rs_value),
        .rt_value   (es_rt_value),
        .commit     (advance && !has_ex),
        .move_value (move_value)
    );

    ex_mem_req u_mem_req (
        .clk          (clk),
        .reset        (reset),
        .mem_op       (es_mem_op),
        .addr         (alu_result),
        .rt_value     (es_rt_value),
        .active       (es_valid && !has_ex),
        .data_addr_ok (data_addr_ok),
        .advance      (advance),
        .addr_error   (addr_error),
        .req_done     (ready_go),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_addr    (data_addr),
        .data_wstrb   (data_wstrb),
        .data_wdata   (data_wdata)
    );

    assign is_load = (es_mem_op == MEM_LW) || (es_mem_op == MEM_LH) ||
                     (es_mem_op == MEM_LHU) || (es_mem_op == MEM_LB) ||
                     (es_mem_op == MEM_LBU);

    // overflow wins over a bad address
    assign addr_fault = addr_error && !overflow;
    assign has_ex     = overflow || addr_error;

    assign out_ex_code   = overflow   ? EX_OV                     :
                           addr_fault ? (is_load ? EX_ADEL : EX_ADES) :
                                        EX_NONE;
    assign out_bad_vaddr = addr_fault ? alu_result : '0;

    assign out_result = ((es_hilo_op == HILO_MFHI) || (es_hilo_op == HILO_MFLO)) ?
                        move_value : alu_result;
    assign out_dest   = es_dest;
    assign out_gr_we  = es_gr_we;
    assign out_pc     = es_pc;
    assign out_load   = is_load;

endmodule

`default_nettype wire

//--- verif/exe_stage_sva.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_sva (
    input logic                    clk,
    input logic                    reset,
    input logic                    out_valid,
    input logic                    out_allowin,
    input ex_pkg::word_t           out_result,
    input ex_pkg::reg_idx_t        out_dest,
    input logic                    out_gr_we,
    input ex_pkg::word_t           out_pc,
    input logic                    out_load,
    input ex_pkg::ex_code_t        out_ex_code,
    input ex_pkg::word_t           out_bad_vaddr,
    input logic                    data_req,
    input logic                    data_addr_ok,
    input logic                    data_wr,
    input ex_pkg::wstrb_t          data_wstrb
);
    import ex_pkg::*;

    logic addr_held;

    // address already taken for the instruction in the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            addr_held <= 1'b0;
        end else if (out_valid && out_allowin) begin
            addr_held <= 1'b0;
        end else if (data_req && data_addr_ok) begin
            addr_held <= 1'b1;
        end
    end

    hold_while_stalled: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> out_valid && $stable(out_result) && $stable(out_dest) &&
            $stable(out_gr_we) && $stable(out_pc) && $stable(out_load) &&
            $stable(out_ex_code) && $stable(out_bad_vaddr))
        else $error("stage outputs changed while the memory stage held it off");

    single_request: assert property (@(posedge clk) disable iff (reset)
        addr_held |-> !data_req)
        else $error("data_req raised again after its address was accepted");

    strobe_only_on_store: assert property (@(posedge clk) disable iff (reset)
        data_wstrb != 4'b0000 |-> data_wr && (data_req || out_valid) &&
            out_ex_code == EX_NONE)
        else $error("byte strobes set without a store in the stage");

endmodule

bind exe_stage exe_stage_sva u_sva (
    .clk           (clk),
    .reset         (reset),
    .out_valid     (out_valid),
    .out_allowin   (out_allowin),
    .out_result    (out_result),
    .out_dest      (out_dest),
    .out_gr_we     (out_gr_we),
    .out_pc        (out_pc),
    .out_load      (out_load),
    .out_ex_code   (out_ex_code),
    .out_bad_vaddr (out_bad_vaddr),
    .data_req      (data_req),
    .data_addr_ok  (data_addr_ok),
    .data_wr       (data_wr),
    .data_wstrb    (data_wstrb)
);

`default_nettype wire

//--- verif/exe_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module exe_stage_tb;
    import ex_pkg::*;

    localparam int NUM_INSTR      = 2000;
    localparam int TIMEOUT_CYCLES = 20 * NUM_INSTR;

    typedef struct packed {
        alu_op_t   alu_op;
        ov_check_t ov_check;
        logic      src1_is_sa;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      src2_is_imm_zero;
        logic      src2_is_8;
        logic      gr_we;
        reg_idx_t  dest;
        imm_t      imm;
        word_t     rs_value;
        word_t     rt_value;
        word_t     pc;
        mem_op_t   mem_op;
        hilo_op_t  hilo_op;
    } instr_t;

    typedef struct packed {
        word_t    result;
        ex_code_t ex_code;
        word_t    bad_vaddr;
        logic     needs_req;
        logic     is_load;
        logic     is_store;
        word_t    addr;
        wstrb_t   wstrb;
        word_t    wdata;
        word_t    next_hi;
        word_t    next_lo;
    } expect_t;

    logic      clk = 1'b0;
    logic      reset;
    logic      in_valid;
    logic      in_allowin;
    alu_op_t   alu_op;
    ov_check_t ov_check;
    logic      src1_is_sa;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      src2_is_imm_zero;
    logic      src2_is_8;
    logic      gr_we;
    reg_idx_t  dest;
    imm_t      imm;
    word_t     rs_value;
    word_t     rt_value;
    word_t     pc;
    mem_op_t   mem_op;
    hilo_op_t  hilo_op;
    logic      out_valid;
    logic      out_allowin;
    word_t     out_result;
    reg_idx_t  out_dest;
    logic      out_gr_we;
    word_t     out_pc;
    logic      out_load;
    ex_code_t  out_ex_code;
    word_t     out_bad_vaddr;
    logic      data_req;
    logic      data_wr;
    word_t     data_addr;
    wstrb_t    data_wstrb;
    word_t     data_wdata;
    logic      data_addr_ok;

    instr_t    cur;
    instr_t    in_flight[$];
    logic      pending = 1'b0;
    logic      req_seen = 1'b0;
    int        issued = 0;
    int        leaves = 0;
    int        cycles = 0;
    // HI and LO as the reference sees them
    word_t     ref_hi = '0;
    word_t     ref_lo = '0;

    exe_stage uut (.*);

    always #4 clk = ~clk;

    task automatic report_failure(string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_word(string name, word_t got, word_t want);
        assert (got === want) else
            report_failure($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, want));
    endtask

    function automatic expect_t ref_execute(instr_t in, word_t hi, word_t lo);
        expect_t     e;
        word_t       s1;
        word_t       s2;
        word_t       alu;
        logic [32:0] wide;
        logic [63:0] ext;
        logic        ov;
        logic        misaligned;
        e = '0;
        s1 = in.src1_is_sa ? {27'b0, in.imm[10:6]} : (in.src1_is_pc ? in.pc : in.rs_value);
        if (in.src2_is_imm_zero) begin
            s2 = {16'h0000, in.imm};
        end else if (in.src2_is_imm) begin
            s2 = {{16{in.imm[15]}}, in.imm};
        end else begin
            s2 = in.src2_is_8 ? 32'd8 : in.rt_value;
        end
        ext = {{32{s2[31]}}, s2} >> s1[4:0];
        case (in.alu_op)
            ALU_ADD:  alu = s1 + s2;
            ALU_SUB:  alu = s1 - s2;
            ALU_SLT:  alu = ($signed(s1) < $signed(s2)) ? 32'd1 : 32'd0;
            ALU_SLTU: alu = (s1 < s2) ? 32'd1 : 32'd0;
            ALU_AND:  alu = s1 & s2;
            ALU_OR:   alu = s1 | s2;
            ALU_XOR:  alu = s1 ^ s2;
            ALU_NOR:  alu = ~(s1 | s2);
            ALU_SLL:  alu = s2 << s1[4:0];
            ALU_SRL:  alu = s2 >> s1[4:0];
            ALU_SRA:  alu = ext[31:0];
            default:  alu = {s2[15:0], 16'h0000};
        endcase
        // 33-bit sum disagrees with its sign bit on overflow
        wide = (in.ov_check == OV_SUB) ? {s1[31], s1} - {s2[31], s2} : {s1[31], s1} + {s2[31], s2};
        ov = (in.ov_check != OV_NONE) && (wide[32] != wide[31]);
        e.is_load  = in.mem_op inside {MEM_LW, MEM_LH, MEM_LHU, MEM_LB, MEM_LBU};
        e.is_store = in.mem_op inside {MEM_SW, MEM_SH, MEM_SB};
        case (in.mem_op)
            MEM_LW, MEM_SW:          misaligned = (alu[1:0] != 2'b00);
            MEM_LH, MEM_LHU, MEM_SH: misaligned = alu[0];
            default:                 misaligned = 1'b0;
        endcase
        if (ov) begin
            e.ex_code = EX_OV;
        end else if (misaligned) begin
            e.ex_code = e.is_load ? EX_ADEL : EX_ADES;
            e.bad_vaddr = alu;
        end else begin
            e.ex_code = EX_NONE;
        end
        e.needs_req = (in.mem_op != MEM_NONE) && (e.ex_code == EX_NONE);
        e.addr = alu;
        e.wdata = in.rt_value;
        case (in.mem_op)
            MEM_SB: begin
                e.wstrb = 4'b0001 << alu[1:0];
                e.wdata = {4{in.rt_value[7:0]}};
            end
            MEM_SH: begin
                e.wstrb = alu[1] ? 4'b1100 : 4'b0011;
                e.wdata = {2{in.rt_value[15:0]}};
            end
            MEM_SW:  e.wstrb = 4'b1111;
            default: e.wstrb = 4'b0000;
        endcase
        e.next_hi = hi;
        e.next_lo = lo;
        ext = '0;
        case (in.hilo_op)
            HILO_MULT:  ext = {{32{in.rs_value[31]}}, in.rs_value} *
                              {{32{in.rt_value[31]}}, in.rt_value};
            HILO_MULTU: ext = {32'b0, in.rs_value} * {32'b0, in.rt_value};
            default:    ext = '0;
        endcase
        if (in.hilo_op == HILO_MULT || in.hilo_op == HILO_MULTU) begin
            e.next_hi = ext[63:32];
            e.next_lo = ext[31:0];
        end else if (in.hilo_op == HILO_MTHI) begin
            e.next_hi = in.rs_value;
        end else if (in.hilo_op == HILO_MTLO) begin
            e.next_lo = in.rs_value;
        end
        if (in.hilo_op == HILO_MFHI) begin
            e.result = hi;
        end else begin
            e.result = (in.hilo_op == HILO_MFLO) ? lo : alu;
        end
        return e;
    endfunction

    // corner values make overflow and sign cases likely
    function automatic word_t pick_operand();
        case ($urandom % 6)
            0:       return 32'h7fff_ffff;
            1:       return 32'h8000_0000;
            2:       return $urandom % 64;
            default: return $urandom;
        endcase
    endfunction

    function automatic instr_t make_instr();
        instr_t      in;
        logic [31:0] r;
        int          kind;
        in = '0;
        r = $urandom;
        kind = $urandom % 8;
        in.alu_op = alu_op_t'($urandom % 12);
        in.imm = r[15:0];
        in.dest = r[20:16];
        in.gr_we = r[21];
        in.rs_value = pick_operand();
        in.rt_value = pick_operand();
        r = $urandom;
        in.pc = {r[31:2], 2'b00};
        if (kind < 3) begin
            in.src1_is_sa = (in.alu_op inside {ALU_SLL, ALU_SRL, ALU_SRA}) && ($urandom % 2 == 0);
            in.src1_is_pc = ($urandom % 8) == 0;
            in.src2_is_imm = ($urandom % 3) == 0;
            in.src2_is_imm_zero = ($urandom % 6) == 0;
            in.src2_is_8 = ($urandom % 8) == 0;
        end else if (kind < 5) begin
            in.alu_op = ALU_ADD;
            in.src2_is_imm = 1'b1;
            in.mem_op = mem_op_t'(1 + $urandom % 8);
        end else if (kind < 7) begin
            in.hilo_op = hilo_op_t'(1 + $urandom % 6);
        end else begin
            in.alu_op = ($urandom % 2 == 0) ? ALU_ADD : ALU_SUB;
            in.hilo_op = ($urandom % 2 == 0) ? HILO_MTHI : HILO_NONE;
        end
        if (kind == 7 || (kind < 5 && ($urandom % 2) == 0)) begin
            if (in.alu_op == ALU_ADD) begin
                in.ov_check = OV_ADD;
            end else if (in.alu_op == ALU_SUB) begin
                in.ov_check = OV_SUB;
            end
        end
        return in;
    endfunction

    task automatic drive_instr(instr_t in);
        alu_op           = in.alu_op;
        ov_check         = in.ov_check;
        src1_is_sa       = in.src1_is_sa;
        src1_is_pc       = in.src1_is_pc;
        src2_is_imm      = in.src2_is_imm;
        src2_is_imm_zero = in.src2_is_imm_zero;
        src2_is_8        = in.src2_is_8;
        gr_we            = in.gr_we;
        dest             = in.dest;
        imm              = in.imm;
        rs_value         = in.rs_value;
        rt_value         = in.rt_value;
        pc               = in.pc;
        mem_op           = in.mem_op;
        hilo_op          = in.hilo_op;
    endtask

    // an offered instruction stays on the inputs until accepted
    task automatic drive_cycle();
        out_allowin  = ($urandom % 4) != 0;
        data_addr_ok = ($urandom % 3) != 0;
        if (!pending) begin
            if (issued < NUM_INSTR && ($urandom % 4) != 0) begin
                cur = make_instr();
                drive_instr(cur);
                in_valid = 1'b1;
                pending = 1'b1;
                issued++;
            end else begin
                in_valid = 1'b0;
            end
        end
    endtask

    task automatic check_request();
        expect_t e;
        assert (in_flight.size() > 0) else
            report_failure("memory request while the stage holds no instruction");
        e = ref_execute(in_flight[0], ref_hi, ref_lo);
        assert (e.needs_req) else
            report_failure("memory request from an instruction that should make none");
        assert (!req_seen) else
            report_failure("second memory request for one instruction");
        check_word("data_addr", data_addr, e.addr);
        check_word("data_wr", {31'b0, data_wr}, {31'b0, e.is_store});
        check_word("data_wstrb", {28'b0, data_wstrb}, {28'b0, e.wstrb});
        if (e.is_store) begin
            check_word("data_wdata", data_wdata, e.wdata);
        end
        req_seen = 1'b1;
    endtask

    task automatic check_leave();
        expect_t e;
        assert (in_flight.size() > 0) else
            report_failure("an instruction left the stage without being accepted");
        e = ref_execute(in_flight[0], ref_hi, ref_lo);
        check_word("out_result", out_result, e.result);
        check_word("out_dest", {27'b0, out_dest}, {27'b0, in_flight[0].dest});
        check_word("out_gr_we", {31'b0, out_gr_we}, {31'b0, in_flight[0].gr_we});
        check_word("out_pc", out_pc, in_flight[0].pc);
        check_word("out_load", {31'b0, out_load}, {31'b0, e.is_load});
        check_word("out_ex_code", {27'b0, out_ex_code}, {27'b0, e.ex_code});
        check_word("out_bad_vaddr", out_bad_vaddr, e.bad_vaddr);
        assert (req_seen == e.needs_req) else
            report_failure("instruction left without exactly one memory request");
        if (e.ex_code == EX_NONE) begin
            ref_hi = e.next_hi;
            ref_lo = e.next_lo;
        end
        void'(in_flight.pop_front());
        req_seen = 1'b0;
        leaves++;
    endtask

    // sample just before the rising edge where every signal has settled
    always begin
        @(negedge clk);
        #3;
        if (!reset) begin
            if (data_req && data_addr_ok) begin
                check_request();
            end
            if (out_valid && out_allowin) begin
                check_leave();
            end
            if (in_valid && in_allowin) begin
                in_flight.push_back(cur);
                pending = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles with %0d instructions done",
                                     cycles, leaves));
        end
    end

    initial begin
        void'($urandom(32'hf20ac238));
        reset = 1'b1;
        in_valid = 1'b0;
        out_allowin = 1'b0;
        data_addr_ok = 1'b0;
        cur = '0;
        drive_instr(cur);
        repeat (16) @(negedge clk);
        reset = 1'b0;
        while (leaves < NUM_INSTR) begin
            drive_cycle();
            @(negedge clk);
        end
        if (!out_valid && in_allowin && in_flight.size() == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            report_failure("stage still busy after the last instruction left");
        end
    end

endmodule

`default_nettype wire

//--- all.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_hilo.sv
verilog/ex_mem_req.sv
verilog/exe_stage.sv
verif/exe_stage_sva.sv
verif/exe_stage_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := exe_stage_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell cat $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
